//--- common/periph_map_pkg.sv
// address map for the peripheral bus; slaves decode only bits 31:28 and the low offset nibble
package periph_map_pkg;

    // slave select field of the byte address
    localparam int SLAVE_MSB = 31;
    localparam int SLAVE_LSB = 28;
    localparam int SLAVE_W   = SLAVE_MSB - SLAVE_LSB + 1;

    // slave base selects, 0x2000_0000 and 0x4000_0000
    localparam logic [SLAVE_W-1:0] SLAVE_TIMER = 4'd2;
    localparam logic [SLAVE_W-1:0] SLAVE_GPIO  = 4'd4;

    // in-slave offset is the low nibble
    localparam int OFFSET_MSB = 3;

    // gpio register offsets
    localparam logic [OFFSET_MSB:0] GPIO_CTRL_OFS = 4'h0;
    localparam logic [OFFSET_MSB:0] GPIO_DATA_OFS = 4'h4;

    // timer register offsets
    localparam logic [OFFSET_MSB:0] TIMER_CTRL_OFS  = 4'h0;
    localparam logic [OFFSET_MSB:0] TIMER_COUNT_OFS = 4'h4;
    localparam logic [OFFSET_MSB:0] TIMER_VALUE_OFS = 4'h8;

    // timer control bits
    // enable, count runs
    localparam int TIMER_EN_BIT   = 0;
    // interrupt enable, gates the pending flag onto irq
    localparam int TIMER_IE_BIT   = 1;
    // pending, set on compare match, write 1 clears
    localparam int TIMER_PEND_BIT = 2;

endpackage

//--- common/gpio_pkg.sv
// gpio pin and mode definitions; only NUM_PINS pins exist though the control word holds 16 modes
package gpio_pkg;

    // physical pins brought out through the pads
    localparam int NUM_PINS = 2;

    // mode field layout of the control word
    localparam int MODE_W     = 2;
    localparam int NUM_FIELDS = 32 / MODE_W;

    // pin mode encoding
    // pin left floating
    localparam logic [MODE_W-1:0] MODE_HIZ = 2'd0;
    // pin driven from its data bit
    localparam logic [MODE_W-1:0] MODE_OUT = 2'd1;
    // data bit follows the synchronized pin
    localparam logic [MODE_W-1:0] MODE_IN  = 2'd2;

    // control word, seen by the bus as a raw register
    // and by the pin logic as one mode field per pin
    // field n sits at bits 2n+1:2n
    typedef union packed {
        logic [31:0]                         raw;
        logic [NUM_FIELDS-1:0][MODE_W-1:0]   mode;
    } gpio_ctrl_u;

    // mode value 3 is reserved and behaves like hi-z

endpackage

//--- gpio/gpio_regs.sv
// gpio control/data registers; data bits above bit 15 are never written, only NUM_PINS pins sampled
module gpio_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [periph_map_pkg::OFFSET_MSB:0] ofs_i,
    input  logic [31:0]                         data_i,
    input  logic [3:0]                          sel_i,
    input  logic                                we_i,
    input  logic [gpio_pkg::NUM_PINS-1:0]       pin_sync_i,
    output logic [31:0]                         data_o,
    output gpio_pkg::gpio_ctrl_u                ctrl_o,
    output logic [31:0]                         gdata_o
);

    // control word, raw and per-pin view
    gpio_pkg::gpio_ctrl_u ctrl_q;

    // data word, low bits map to pins
    logic [31:0] gdata_q;

    // registered read data
    logic [31:0] rdata_q;

    // decoded write strobes
    logic ctrl_wr;
    logic data_wr;

    assign ctrl_wr = we_i && (ofs_i == periph_map_pkg::GPIO_CTRL_OFS);
    assign data_wr = we_i && (ofs_i == periph_map_pkg::GPIO_DATA_OFS);

    // control register, every byte writable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    ctrl_q.raw[b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end
    end

    // data register
    // software write takes the low two bytes only
    // otherwise input-mode pins load their synced level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gdata_q <= '0;
        end else if (data_wr) begin
            if (sel_i[0]) begin
                gdata_q[7:0] <= data_i[7:0];
            end
            if (sel_i[1]) begin
                gdata_q[15:8] <= data_i[15:8];
            end
        end else begin
            for (int p = 0; p < gpio_pkg::NUM_PINS; p++) begin
                if (ctrl_q.mode[p] == gpio_pkg::MODE_IN) begin
                    gdata_q[p] <= pin_sync_i[p];
                end
            end
        end
    end

    // read path, one cycle latency
    // zero on writes and on holes in the map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (!we_i) begin
            case (ofs_i)
                periph_map_pkg::GPIO_CTRL_OFS: rdata_q <= ctrl_q.raw;
                periph_map_pkg::GPIO_DATA_OFS: rdata_q <= gdata_q;
                default:                       rdata_q <= '0;
            endcase
        end else begin
            rdata_q <= '0;
        end
    end

    assign data_o  = rdata_q;
    assign ctrl_o  = ctrl_q;
    assign gdata_o = gdata_q;

    // a write cycle never leaves stale read data for the bus mux
    a_wr_clears_rdata: assert property (
        @(posedge clk) disable iff (!rst_n)
        we_i |=> (data_o == '0)
    );

endmodule

//--- gpio/gpio_pads.sv
// pad logic for NUM_PINS pins; io_out_o/io_oe_o are combinational, inputs see two sync flops
module gpio_pads (
    input  logic                          clk,
    input  logic                          rst_n,
    input  gpio_pkg::gpio_ctrl_u          ctrl_i,
    input  logic [31:0]                   gdata_i,
    input  logic [gpio_pkg::NUM_PINS-1:0] io_pin_i,
    output logic [gpio_pkg::NUM_PINS-1:0] io_out_o,
    output logic [gpio_pkg::NUM_PINS-1:0] io_oe_o,
    output logic [gpio_pkg::NUM_PINS-1:0] pin_sync_o
);

    // synchronizer stages
    logic [gpio_pkg::NUM_PINS-1:0] sync1_q;
    logic [gpio_pkg::NUM_PINS-1:0] sync2_q;

    // output enable from mode field
    // value only driven when enabled, so a hi-z pin shows 0
    always_comb begin
        for (int p = 0; p < gpio_pkg::NUM_PINS; p++) begin
            io_oe_o[p]  = (ctrl_i.mode[p] == gpio_pkg::MODE_OUT);
            io_out_o[p] = gdata_i[p] & io_oe_o[p];
        end
    end

    // two-flop synchronizer, pins are asynchronous to clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= io_pin_i;
            sync2_q <= sync1_q;
        end
    end

    // second stage goes to the register block
    assign pin_sync_o = sync2_q;

endmodule

//--- hdl/timer.sv
// compare-match timer; count wraps to 0 when it equals value, a count write wins over counting
module timer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [periph_map_pkg::OFFSET_MSB:0] ofs_i,
    input  logic [31:0]                         data_i,
    input  logic [3:0]                          sel_i,
    input  logic                                we_i,
    output logic [31:0]                         data_o,
    output logic                                irq_o
);

    // registers
    logic [31:0] ctrl_q;
    logic [31:0] count_q;
    logic [31:0] value_q;
    logic        pend_q;
    logic [31:0] rdata_q;

    // decode and status
    logic        ctrl_wr;
    logic        count_wr;
    logic        value_wr;
    logic        enabled;
    logic        match;
    logic        pend_clr;
    logic [31:0] ctrl_rd;

    assign ctrl_wr  = we_i && (ofs_i == periph_map_pkg::TIMER_CTRL_OFS);
    assign count_wr = we_i && (ofs_i == periph_map_pkg::TIMER_COUNT_OFS);
    assign value_wr = we_i && (ofs_i == periph_map_pkg::TIMER_VALUE_OFS);

    assign enabled = ctrl_q[periph_map_pkg::TIMER_EN_BIT];
    assign match   = enabled && (count_q == value_q);

    // w1c on the pending bit, needs its byte selected
    assign pend_clr = ctrl_wr && sel_i[periph_map_pkg::TIMER_PEND_BIT / 8]
                      && data_i[periph_map_pkg::TIMER_PEND_BIT];

    // control, pending bit kept out of the plain storage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (ctrl_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    ctrl_q[b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
            ctrl_q[periph_map_pkg::TIMER_PEND_BIT] <= 1'b0;
        end
    end

    // counter, software write first, then wrap, then increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (count_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    count_q[b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end else if (match) begin
            count_q <= '0;
        end else if (enabled) begin
            count_q <= count_q + 32'd1;
        end
    end

    // compare value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_q <= '0;
        end else if (value_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    value_q[b*8 +: 8] <= data_i[b*8 +: 8];
                end
            end
        end
    end

    // pending flag, a match in the clear cycle is not lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
        end else if (match) begin
            pend_q <= 1'b1;
        end else if (pend_clr) begin
            pend_q <= 1'b0;
        end
    end

    // control readback with live pending bit
    always_comb begin
        ctrl_rd = ctrl_q;
        ctrl_rd[periph_map_pkg::TIMER_PEND_BIT] = pend_q;
    end

    // read path, same scheme as gpio
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (!we_i) begin
            case (ofs_i)
                periph_map_pkg::TIMER_CTRL_OFS:  rdata_q <= ctrl_rd;
                periph_map_pkg::TIMER_COUNT_OFS: rdata_q <= count_q;
                periph_map_pkg::TIMER_VALUE_OFS: rdata_q <= value_q;
                default:                         rdata_q <= '0;
            endcase
        end else begin
            rdata_q <= '0;
        end
    end

    assign data_o = rdata_q;
    assign irq_o  = pend_q & ctrl_q[periph_map_pkg::TIMER_IE_BIT];

    // count stays inside the compare window while running
    a_count_le_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enabled && (value_q != '0)) |-> (count_q <= value_q)
    );

endmodule

//--- hdl/periph_bus.sv
// bus decoder for two slaves; no error response, unmapped reads return zero one cycle later
module periph_bus (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr_i,
    input  logic        we_i,
    input  logic [31:0] gpio_rdata_i,
    input  logic [31:0] timer_rdata_i,
    output logic        gpio_we_o,
    output logic        timer_we_o,
    output logic [31:0] data_o
);

    // slave field of the address
    logic [periph_map_pkg::SLAVE_W-1:0] slave;
    logic                               hit_gpio;
    logic                               hit_timer;

    // read select, one per slave, from the previous cycle
    logic rd_gpio_q;
    logic rd_timer_q;

    assign slave     = addr_i[periph_map_pkg::SLAVE_MSB:periph_map_pkg::SLAVE_LSB];
    assign hit_gpio  = (slave == periph_map_pkg::SLAVE_GPIO);
    assign hit_timer = (slave == periph_map_pkg::SLAVE_TIMER);

    // write enable only to the addressed slave
    assign gpio_we_o  = we_i && hit_gpio;
    assign timer_we_o = we_i && hit_timer;

    // remember who was read, cleared on writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_gpio_q  <= 1'b0;
            rd_timer_q <= 1'b0;
        end else begin
            rd_gpio_q  <= !we_i && hit_gpio;
            rd_timer_q <= !we_i && hit_timer;
        end
    end

    // slave data is already registered, mux aligns with it
    always_comb begin
        if (rd_gpio_q) begin
            data_o = gpio_rdata_i;
        end else if (rd_timer_q) begin
            data_o = timer_rdata_i;
        end else begin
            data_o = '0;
        end
    end

    a_one_we: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(gpio_we_o && timer_we_o)
    );

endmodule

//--- hdl/periph_top.sv
// peripheral top with gpio and timer; every cycle is an access, no wait states or bus errors
module periph_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   addr_i,
    input  logic [31:0]                   data_i,
    input  logic [3:0]                    sel_i,
    input  logic                          we_i,
    output logic [31:0]                   data_o,
    input  logic [gpio_pkg::NUM_PINS-1:0] io_pin_i,
    output logic [gpio_pkg::NUM_PINS-1:0] io_out_o,
    output logic [gpio_pkg::NUM_PINS-1:0] io_oe_o,
    output logic                          timer_irq_o
);

    // decoder to slaves
    logic        gpio_we;
    logic        timer_we;
    logic [31:0] gpio_rdata;
    logic [31:0] timer_rdata;

    // gpio registers to pads and back
    gpio_pkg::gpio_ctrl_u          gpio_ctrl;
    logic [31:0]                   gpio_gdata;
    logic [gpio_pkg::NUM_PINS-1:0] pin_sync;

    periph_bus u_bus (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr_i        (addr_i),
        .we_i          (we_i),
        .gpio_rdata_i  (gpio_rdata),
        .timer_rdata_i (timer_rdata),
        .gpio_we_o     (gpio_we),
        .timer_we_o    (timer_we),
        .data_o        (data_o)
    );

    gpio_regs u_gpio_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .ofs_i      (addr_i[periph_map_pkg::OFFSET_MSB:0]),
        .data_i     (data_i),
        .sel_i      (sel_i),
        .we_i       (gpio_we),
        .pin_sync_i (pin_sync),
        .data_o     (gpio_rdata),
        .ctrl_o     (gpio_ctrl),
        .gdata_o    (gpio_gdata)
    );

    gpio_pads u_gpio_pads (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_i     (gpio_ctrl),
        .gdata_i    (gpio_gdata),
        .io_pin_i   (io_pin_i),
        .io_out_o   (io_out_o),
        .io_oe_o    (io_oe_o),
        .pin_sync_o (pin_sync)
    );

    timer u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .ofs_i  (addr_i[periph_map_pkg::OFFSET_MSB:0]),
        .data_i (data_i),
        .sel_i  (sel_i),
        .we_i   (timer_we),
        .data_o (timer_rdata),
        .irq_o  (timer_irq_o)
    );

endmodule

//--- verification/periph_checker.sv
// samples the DUT on the falling edge of each strobed cycle; pad checks pack {oe, out} into bits 3:0
module periph_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          chk_stb_i,
    input  logic [7:0]                    chk_op_i,
    input  logic [31:0]                   chk_exp_i,
    input  logic [127:0]                  chk_name_i,
    input  logic                          done_i,
    input  logic [31:0]                   data_i,
    input  logic [gpio_pkg::NUM_PINS-1:0] io_out_i,
    input  logic [gpio_pkg::NUM_PINS-1:0] io_oe_i,
    input  logic                          irq_i,
    output int                            pass_cnt_o,
    output int                            fail_cnt_o
);

    int          pass_cnt = 0;
    int          fail_cnt = 0;
    bit          reported = 1'b0;
    logic [31:0] actual;

    // mid-cycle sample, all dut outputs settled
    always @(negedge clk) begin
        if (rst_n && chk_stb_i) begin
            case (chk_op_i)
                "R": actual = data_i;
                "O": actual = {{(32 - 2 * gpio_pkg::NUM_PINS){1'b0}}, io_oe_i, io_out_i};
                default: actual = {31'b0, irq_i};
            endcase
            // x or z on an output counts as a mismatch
            if (actual === chk_exp_i) begin
                pass_cnt++;
                $display("ok       %0s  %h", chk_name_i, actual);
            end else begin
                fail_cnt++;
                $display("** Error %0s: expected %h, actual %h", chk_name_i, chk_exp_i, actual);
            end
        end
        if (done_i && !reported) begin
            reported = 1'b1;
            $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        end
    end

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

endmodule

//--- verification/periph_tb.sv
// runs verification/periph_vectors.txt from the project root; test names are cut to 16 characters
module periph_tb;

    localparam int NAME_W = 128;

    // dut side
    logic                          clk;
    logic                          rst_n;
    logic [31:0]                   addr;
    logic [31:0]                   wdata;
    logic [3:0]                    sel;
    logic                          we;
    logic [31:0]                   rdata;
    logic [gpio_pkg::NUM_PINS-1:0] io_pin;
    logic [gpio_pkg::NUM_PINS-1:0] io_out;
    logic [gpio_pkg::NUM_PINS-1:0] io_oe;
    logic                          irq;

    // check request to the checker
    logic              chk_stb;
    logic [7:0]        chk_op;
    logic [31:0]       chk_exp;
    logic [NAME_W-1:0] chk_name;
    logic              done;
    int                pass_cnt;
    int                fail_cnt;

    // vector table, one entry per file line
    byte               vec_op[$];
    logic [NAME_W-1:0] vec_name[$];
    logic [31:0]       vec_addr[$];
    logic [31:0]       vec_data[$];
    logic [3:0]        vec_sel[$];
    logic [31:0]       vec_exp[$];

    int          cycles = 0;
    int          limit = 0;
    int          n_checks = 0;
    bit          bad_file = 1'b0;
    int unsigned seed;

    periph_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_i      (addr),
        .data_i      (wdata),
        .sel_i       (sel),
        .we_i        (we),
        .data_o      (rdata),
        .io_pin_i    (io_pin),
        .io_out_o    (io_out),
        .io_oe_o     (io_oe),
        .timer_irq_o (irq)
    );

    periph_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .chk_stb_i  (chk_stb),
        .chk_op_i   (chk_op),
        .chk_exp_i  (chk_exp),
        .chk_name_i (chk_name),
        .done_i     (done),
        .data_i     (rdata),
        .io_out_i   (io_out),
        .io_oe_i    (io_oe),
        .irq_i      (irq),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit, armed once the vectors are loaded
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the vector list did not complete", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // string name into a fixed packed field for the checker port
    function automatic logic [NAME_W-1:0] pack_name(input string s);
        logic [NAME_W-1:0] v;
        v = '0;
        for (int i = 0; i < s.len() && i < NAME_W / 8; i++) begin
            v = {v[NAME_W-9:0], s[i]};
        end
        return v;
    endfunction

    // cycles one vector line takes, a read needs its result cycle too
    function automatic int op_cost(input byte op, input logic [31:0] n);
        if (op == "R") begin
            return 2;
        end else if (op == "D") begin
            return int'(n);
        end
        return 1;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          r;
        int          total;
        string       op;
        string       nm;
        string       rest;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [3:0]  s;
        total = 0;
        fd = $fopen("verification/periph_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/periph_vectors.txt");
            bad_file = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                r = $fscanf(fd, "%s", op);
                if (r == 1 && op[0] == "#") begin
                    r = $fgets(rest, fd);
                end else if (r == 1) begin
                    r = $fscanf(fd, "%s %h %h %h %h", nm, a, d, s, e);
                    if (r != 5 || op.len() != 1) begin
                        $display("malformed vector line near test %s", nm);
                        bad_file = 1'b1;
                    end else begin
                        vec_op.push_back(op[0]);
                        vec_name.push_back(pack_name(nm));
                        vec_addr.push_back(a);
                        vec_data.push_back(d);
                        vec_sel.push_back(s);
                        vec_exp.push_back(e);
                        total += op_cost(op[0], d);
                        if (op[0] == "R" || op[0] == "O" || op[0] == "I") begin
                            n_checks++;
                        end
                        if (op != "W" && op != "R" && op != "P" && op != "O" &&
                            op != "I" && op != "D") begin
                            $display("unknown operation %s in test %s", op, nm);
                            bad_file = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        limit = 2 * total + 100;
    endtask

    task automatic drive_bus(input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] s, input logic w);
        addr    <= a;
        wdata   <= d;
        sel     <= s;
        we      <= w;
        chk_stb <= 1'b0;
    endtask

    // idle cycle reads slave 0, which is unmapped
    task automatic drive_idle();
        drive_bus(32'h0, 32'h0, 4'h0, 1'b0);
    endtask

    task automatic raise_check(input int i);
        chk_stb  <= 1'b1;
        chk_op   <= vec_op[i];
        chk_exp  <= vec_exp[i];
        chk_name <= vec_name[i];
    endtask

    task automatic run_vector(input int i);
        case (vec_op[i])
            "W": begin
                @(posedge clk);
                drive_bus(vec_addr[i], vec_data[i], vec_sel[i], 1'b1);
            end
            "R": begin
                // write data is a don't care on a read
                @(posedge clk);
                drive_bus(vec_addr[i], $urandom(), vec_sel[i], 1'b0);
                @(posedge clk);
                drive_idle();
                raise_check(i);
            end
            "P": begin
                @(posedge clk);
                drive_idle();
                io_pin <= vec_data[i][gpio_pkg::NUM_PINS-1:0];
            end
            "D": begin
                repeat (vec_data[i]) begin
                    @(posedge clk);
                    drive_idle();
                end
            end
            default: begin
                // pad and irq checks look at the current cycle
                @(posedge clk);
                drive_idle();
                raise_check(i);
            end
        endcase
    endtask

    initial begin
        rst_n    = 1'b0;
        addr     = '0;
        wdata    = '0;
        sel      = '0;
        we       = 1'b0;
        io_pin   = '0;
        chk_stb  = 1'b0;
        chk_op   = '0;
        chk_exp  = '0;
        chk_name = '0;
        done     = 1'b0;
        seed     = $urandom(22909);
        load_vectors();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < vec_op.size(); i++) begin
            run_vector(i);
        end
        @(posedge clk);
        drive_idle();
        done <= 1'b1;
        @(posedge clk);
        if (!bad_file && n_checks > 0 && fail_cnt == 0 && pass_cnt == n_checks) begin
            $display("sim passed");
        end else begin
            if (pass_cnt + fail_cnt != n_checks) begin
                $display("only %0d of %0d checks ran", pass_cnt + fail_cnt, n_checks);
            end
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verification/periph_vectors.txt
# op name addr data sel expected, numbers in hex
# W write, R read, P set pins, O pads {oe,out}, I irq level, D idle for data cycles
R rst_gpio_ctrl 40000000 0 f 00000000
R rst_gpio_data 40000004 0 f 00000000
R rst_tmr_ctrl 20000000 0 f 00000000
R rst_tmr_count 20000004 0 f 00000000
R rst_tmr_value 20000008 0 f 00000000
O rst_pads 0 0 0 0
I rst_irq 0 0 0 0
W ctrl_all 40000000 a5a5a5a5 f 0
W ctrl_byte2 40000000 00ff0000 4 0
R bsel_ctrl 40000000 0 f a5ffa5a5
W data_all 40000004 ffffffff f 0
R bsel_data 40000004 0 f 0000ffff
W data_byte1 40000004 00001200 2 0
R bsel_data_b1 40000004 0 f 000012ff
W ctrl_out0 40000000 00000001 f 0
O out_mode 0 0 0 5
W ctrl_in1 40000000 00000009 1 0
W data_out0 40000004 00000001 3 0
P pin1_high 0 2 0 0
D settle_hi 0 6 0 0
R in_mode_hi 40000004 0 f 00000003
O in_pads 0 0 0 5
P pin1_low 0 0 0 0
D settle_lo 0 6 0 0
R in_mode_lo 40000004 0 f 00000001
W tmr_value 20000008 00000009 f 0
W tmr_run 20000000 00000003 f 0
D tmr_wait 0 14 0 0
I irq_on 0 0 0 1
R tmr_pending 20000000 0 f 00000007
W tmr_stop 20000000 00000002 f 0
I irq_held 0 0 0 1
W tmr_clear 20000000 00000006 f 0
I irq_off 0 0 0 0
R tmr_ctrl_clr 20000000 0 f 00000002
R tmr_value_rd 20000008 0 f 00000009
R unmapped_3 30000000 0 f 00000000
R unmapped_f f0000004 0 f 00000000

//--- list.f
common/periph_map_pkg.sv
common/gpio_pkg.sv
gpio/gpio_regs.sv
gpio/gpio_pads.sv
hdl/timer.sv
hdl/periph_bus.sv
hdl/periph_top.sv
verification/periph_checker.sv
verification/periph_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = periph_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
